/* logic/meta_pkg.sv */
`default_nettype none

package meta_pkg;

  // branch kinds, codes 6 and 7 are not branches.
  typedef logic [2:0] kind_t;

  localparam kind_t BEQ  = 3'd5;
  localparam kind_t BNE  = 3'd4;
  localparam kind_t BLT  = 3'd3;
  localparam kind_t BGE  = 3'd2;
  localparam kind_t BLTU = 3'd1;
  localparam kind_t BGEU = 3'd0;

  localparam int NUM_KINDS   = 6;
  localparam int COUNT_WIDTH = 2; // lhp and ghp direction counters.

  typedef enum logic [1:0]
  {
    SRC_SP  = 2'd0,
    SRC_LHP = 2'd1,
    SRC_GHP = 2'd2
  } source_t;

  typedef struct packed
  {
    kind_t                  kind;
    logic                   sp_taken;
    logic [COUNT_WIDTH-1:0] lhp_count;
    logic [COUNT_WIDTH-1:0] ghp_count;
  } branch_query_t;

  typedef struct packed
  {
    branch_query_t query;
    logic          taken; // resolved direction.
  } branch_update_t;

  function automatic logic kind_valid(kind_t kind);
    return kind < kind_t'(NUM_KINDS);
  endfunction

endpackage

`default_nettype wire

/* logic/confidence_table.sv */
`timescale 1ns/1ps
`default_nettype none

module confidence_table #(
  parameter int unsigned INDEX_WIDTH = 1,
  parameter int unsigned STAT_WIDTH = 6,
  parameter logic [STAT_WIDTH-1:0] STAT_INIT = '0
)(
  input  wire                    clk,
  input  wire                    rst_n,
  input  meta_pkg::kind_t        rd_kind,
  input  wire  [INDEX_WIDTH-1:0] rd_index,
  output logic [STAT_WIDTH-1:0]  rd_stat,
  input  wire                    wr_en,
  input  meta_pkg::kind_t        wr_kind,
  input  wire  [INDEX_WIDTH-1:0] wr_index,
  input  wire                    wr_taken
);

  localparam int DEPTH = 2 ** INDEX_WIDTH;
  localparam logic [STAT_WIDTH-1:0] STAT_MAX = {STAT_WIDTH{1'b1}};

  logic [STAT_WIDTH-1:0] stat_mem [meta_pkg::NUM_KINDS][DEPTH];

  meta_pkg::kind_t       rd_row;
  meta_pkg::kind_t       wr_row;
  logic                  wr_valid;
  logic                  wr_hit;
  logic [STAT_WIDTH-1:0] wr_cur;
  logic [STAT_WIDTH-1:0] wr_next;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // read port.
  always_comb
  begin
    rd_row = meta_pkg::kind_valid(rd_kind) ? rd_kind : '0; // keep the row in range.
    if (meta_pkg::kind_valid(rd_kind))
    begin
      rd_stat = stat_mem[rd_row][rd_index];
    end
    else
    begin
      rd_stat = '0; // not a branch.
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // write port, saturating step.
  always_comb
  begin
    wr_valid = wr_en && meta_pkg::kind_valid(wr_kind);
    wr_row   = meta_pkg::kind_valid(wr_kind) ? wr_kind : '0;
    wr_cur   = stat_mem[wr_row][wr_index];
    wr_hit   = wr_index[INDEX_WIDTH-1] == wr_taken; // top index bit is the guess.
    wr_next  = wr_cur;
    if (wr_hit && wr_cur != STAT_MAX)
    begin
      wr_next = wr_cur + 1'b1;
    end
    else if (!wr_hit && wr_cur != '0)
    begin
      wr_next = wr_cur - 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int k = 0; k < meta_pkg::NUM_KINDS; k++)
      begin
        for (int i = 0; i < DEPTH; i++)
        begin
          stat_mem[k][i] <= STAT_INIT;
        end
      end
    end
    else if (wr_valid)
    begin
      stat_mem[wr_row][wr_index] <= wr_next;
    end
  end

endmodule

`default_nettype wire

/* logic/update_handshake.sv */
`timescale 1ns/1ps
`default_nettype none

module update_handshake (
  input  wire                      clk,
  input  wire                      rst_n,
  input  meta_pkg::branch_update_t update,
  input  wire                      update_req,
  output logic                     update_ack,
  output logic                     wr_en,
  output meta_pkg::branch_update_t wr_rec
);

  typedef enum logic
  {
    IDLE  = 1'b0,
    ACKED = 1'b1
  } hs_state_t;

  hs_state_t state;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // four-phase req/ack control.
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state      <= IDLE;
      update_ack <= 1'b0;
      wr_en      <= 1'b0;
    end
    else
    begin
      wr_en <= 1'b0; // single cycle write strobe.
      case (state)
        IDLE:
        begin
          if (update_req)
          begin
            state      <= ACKED;
            update_ack <= 1'b1;
            wr_en      <= 1'b1;
          end
        end
        ACKED:
        begin
          // hold ack until the requester lets go.
          if (!update_req)
          begin
            state      <= IDLE;
            update_ack <= 1'b0;
          end
        end
        default:
        begin
          state      <= IDLE;
          update_ack <= 1'b0;
        end
      endcase
    end
  end

  // record is captured once per handshake.
  always_ff @(posedge clk)
  begin
    if (state == IDLE && update_req)
    begin
      wr_rec <= update;
    end
  end

endmodule

`default_nettype wire

/* logic/source_select.sv */
`timescale 1ns/1ps
`default_nettype none

module source_select #(
  parameter int unsigned STAT_WIDTH = 6
)(
  input  wire  [STAT_WIDTH-1:0] sp_stat,
  input  wire  [STAT_WIDTH-1:0] lhp_stat,
  input  wire  [STAT_WIDTH-1:0] ghp_stat,
  input  wire                   sp_taken,
  input  wire                   lhp_taken,
  input  wire                   ghp_taken,
  output logic                  prediction_taken,
  output meta_pkg::source_t     prediction_source
);

  logic ghp_wins;
  logic lhp_wins;

  // ties go to ghp, then lhp.
  always_comb
  begin
    ghp_wins = (ghp_stat >= lhp_stat) && (ghp_stat >= sp_stat);
    lhp_wins = !ghp_wins && (lhp_stat >= sp_stat);

    if (ghp_wins)
    begin
      prediction_source = meta_pkg::SRC_GHP;
      prediction_taken  = ghp_taken;
    end
    else if (lhp_wins)
    begin
      prediction_source = meta_pkg::SRC_LHP;
      prediction_taken  = lhp_taken;
    end
    else
    begin
      prediction_source = meta_pkg::SRC_SP;
      prediction_taken  = sp_taken;
    end
  end

endmodule

`default_nettype wire

/* logic/meta_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module meta_predictor #(
  parameter int unsigned STAT_WIDTH = 6,
  parameter logic [STAT_WIDTH-1:0] SP_STAT_INIT = 2,
  parameter logic [STAT_WIDTH-1:0] LHP_STAT_INIT = 1,
  parameter logic [STAT_WIDTH-1:0] GHP_STAT_INIT = 0
)(
  input  wire                      clk,
  input  wire                      rst_n,
  input  meta_pkg::branch_query_t  query,
  output logic                     prediction_taken,
  output meta_pkg::source_t        prediction_source,
  input  meta_pkg::branch_update_t update,
  input  wire                      update_req,
  output logic                     update_ack
);

  localparam int CW = meta_pkg::COUNT_WIDTH;

  logic                     wr_en;
  meta_pkg::branch_update_t wr_rec;
  logic [STAT_WIDTH-1:0]    sp_stat;
  logic [STAT_WIDTH-1:0]    lhp_stat;
  logic [STAT_WIDTH-1:0]    ghp_stat;

  update_handshake update_handshake_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .update     (update),
    .update_req (update_req),
    .update_ack (update_ack),
    .wr_en      (wr_en),
    .wr_rec     (wr_rec)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // one table per sub-predictor, indexed by its own state.
  confidence_table #(
    .INDEX_WIDTH (1),
    .STAT_WIDTH  (STAT_WIDTH),
    .STAT_INIT   (SP_STAT_INIT)
  ) sp_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_kind  (query.kind),
    .rd_index (query.sp_taken),
    .rd_stat  (sp_stat),
    .wr_en    (wr_en),
    .wr_kind  (wr_rec.query.kind),
    .wr_index (wr_rec.query.sp_taken),
    .wr_taken (wr_rec.taken)
  );

  confidence_table #(
    .INDEX_WIDTH (CW),
    .STAT_WIDTH  (STAT_WIDTH),
    .STAT_INIT   (LHP_STAT_INIT)
  ) lhp_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_kind  (query.kind),
    .rd_index (query.lhp_count),
    .rd_stat  (lhp_stat),
    .wr_en    (wr_en),
    .wr_kind  (wr_rec.query.kind),
    .wr_index (wr_rec.query.lhp_count),
    .wr_taken (wr_rec.taken)
  );

  confidence_table #(
    .INDEX_WIDTH (CW),
    .STAT_WIDTH  (STAT_WIDTH),
    .STAT_INIT   (GHP_STAT_INIT)
  ) ghp_table (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_kind  (query.kind),
    .rd_index (query.ghp_count),
    .rd_stat  (ghp_stat),
    .wr_en    (wr_en),
    .wr_kind  (wr_rec.query.kind),
    .wr_index (wr_rec.query.ghp_count),
    .wr_taken (wr_rec.taken)
  );

  source_select #(
    .STAT_WIDTH (STAT_WIDTH)
  ) source_select_i (
    .sp_stat           (sp_stat),
    .lhp_stat          (lhp_stat),
    .ghp_stat          (ghp_stat),
    .sp_taken          (query.sp_taken),
    .lhp_taken         (query.lhp_count[CW-1]), // counter msb is the guess.
    .ghp_taken         (query.ghp_count[CW-1]),
    .prediction_taken  (prediction_taken),
    .prediction_source (prediction_source)
  );

endmodule

`default_nettype wire

/* tests/meta_predictor_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module meta_predictor_sva (
  input wire clk,
  input wire rst_n,
  input wire update_req,
  input wire update_ack,
  input wire wr_en
);

  // ack only answers a request seen at the previous edge.
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(update_ack) |-> $past(update_req))
    else $error("update_ack rose without update_req");

  write_on_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |-> $rose(update_ack))
    else $error("wr_en high outside the rise of update_ack");

  ack_rise_writes: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(update_ack) |-> wr_en)
    else $error("update_ack rose without a table write");

  write_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    wr_en |=> !wr_en)
    else $error("wr_en lasted more than one cycle");

  ack_held: assert property (@(posedge clk) disable iff (!rst_n)
    update_req && update_ack |=> update_ack)
    else $error("update_ack dropped while update_req was high");

endmodule

bind update_handshake meta_predictor_sva meta_predictor_sva_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .update_req (update_req),
  .update_ack (update_ack),
  .wr_en      (wr_en)
);

`default_nettype wire

/* tests/tb_meta_predictor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_meta_predictor;

  localparam int STAT_WIDTH   = 6;
  localparam int STAT_MAX     = 2 ** STAT_WIDTH - 1;
  localparam int RESET_CYCLES = 16;
  localparam int HS_LIMIT     = 8; // falling edges allowed for each ack change.
  localparam int TEST_CYCLES  = 8 * (RESET_CYCLES + 2) + 320 * 8 + 1100 * 2;
  localparam int WATCHDOG_NS  = TEST_CYCLES * 20;

  logic                     clk = 1'b0;
  logic                     rst_n;
  meta_pkg::branch_query_t  query;
  logic                     prediction_taken;
  meta_pkg::source_t        prediction_source;
  meta_pkg::branch_update_t update;
  logic                     update_req;
  logic                     update_ack;

  int          sp_ref  [meta_pkg::NUM_KINDS][2];
  int          lhp_ref [meta_pkg::NUM_KINDS][4];
  int          ghp_ref [meta_pkg::NUM_KINDS][4];
  int          errors = 0;
  int          checks = 0;
  logic [31:0] lfsr   = 32'h1ed8_3344;

  meta_predictor #(
    .STAT_WIDTH    (STAT_WIDTH),
    .SP_STAT_INIT  (2),
    .LHP_STAT_INIT (1),
    .GHP_STAT_INIT (0)
  ) meta_predictor_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .query             (query),
    .prediction_taken  (prediction_taken),
    .prediction_source (prediction_source),
    .update            (update),
    .update_req        (update_req),
    .update_ack        (update_ack)
  );

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // reference model.
  task automatic model_init();
    for (int k = 0; k < meta_pkg::NUM_KINDS; k++)
    begin
      for (int i = 0; i < 2; i++)
        sp_ref[k][i] = 2;
      for (int i = 0; i < 4; i++)
      begin
        lhp_ref[k][i] = 1;
        ghp_ref[k][i] = 0;
      end
    end
  endtask

  function automatic int step(int cur, logic guess, logic taken);
    if (guess == taken)
      return (cur == STAT_MAX) ? cur : cur + 1;
    return (cur == 0) ? 0 : cur - 1;
  endfunction

  task automatic model_update(input meta_pkg::branch_update_t rec);
    meta_pkg::branch_query_t q;
    q = rec.query;
    if (q.kind < 3'd6) // kinds 6 and 7 are dropped.
    begin
      sp_ref[q.kind][q.sp_taken]   = step(sp_ref[q.kind][q.sp_taken], q.sp_taken, rec.taken);
      lhp_ref[q.kind][q.lhp_count] = step(lhp_ref[q.kind][q.lhp_count], q.lhp_count[1],
                                          rec.taken);
      ghp_ref[q.kind][q.ghp_count] = step(ghp_ref[q.kind][q.ghp_count], q.ghp_count[1],
                                          rec.taken);
    end
  endtask

  function automatic void predict(input meta_pkg::branch_query_t q,
                                  output meta_pkg::source_t src, output logic taken);
    int sp_c;
    int lhp_c;
    int ghp_c;
    sp_c  = 0;
    lhp_c = 0;
    ghp_c = 0;
    if (q.kind < 3'd6)
    begin
      sp_c  = sp_ref[q.kind][q.sp_taken];
      lhp_c = lhp_ref[q.kind][q.lhp_count];
      ghp_c = ghp_ref[q.kind][q.ghp_count];
    end
    src   = meta_pkg::SRC_SP;
    taken = q.sp_taken;
    if (ghp_c >= lhp_c && ghp_c >= sp_c)
    begin
      src   = meta_pkg::SRC_GHP;
      taken = q.ghp_count[1];
    end
    else if (lhp_c >= sp_c)
    begin
      src   = meta_pkg::SRC_LHP;
      taken = q.lhp_count[1];
    end
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // helpers.
  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0t %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]}; // taps 32 22 2 1.
      val  = {val[30:0], lfsr[0]};
    end
    return val;
  endfunction

  function automatic meta_pkg::branch_update_t make_rec(meta_pkg::kind_t kind, logic sp,
                                                         logic [1:0] lhp, logic [1:0] ghp,
                                                         logic taken);
    meta_pkg::branch_update_t rec;
    rec.query.kind      = kind;
    rec.query.sp_taken  = sp;
    rec.query.lhp_count = lhp;
    rec.query.ghp_count = ghp;
    rec.taken           = taken;
    return rec;
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst_n      <= 1'b0;
    update_req <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    model_init();
    @(negedge clk);
  endtask

  // full four-phase handshake, edge counts start where req is driven.
  task automatic resolve(input meta_pkg::branch_update_t rec, input int hold,
                         output int rise, output int fall);
    rise = 0;
    fall = 0;
    @(posedge clk);
    update     <= rec;
    update_req <= 1'b1;
    do
    begin
      @(negedge clk);
      rise++;
    end
    while (!update_ack && rise < HS_LIMIT);
    if (!update_ack)
    begin
      errors++;
      $display("handshake stalled, no ack within %0d cycles at %0t", HS_LIMIT, $time);
    end
    repeat (hold) @(posedge clk);
    @(posedge clk);
    update_req <= 1'b0;
    do
    begin
      @(negedge clk);
      fall++;
    end
    while (update_ack && fall < HS_LIMIT);
    if (update_ack)
    begin
      errors++;
      $display("handshake stalled, ack still high %0d cycles after req fell", HS_LIMIT);
    end
    model_update(rec);
  endtask

  task automatic resolve_n(input meta_pkg::branch_update_t rec, input int n);
    int rise;
    int fall;
    repeat (n) resolve(rec, 0, rise, fall);
  endtask

  task automatic query_check(input meta_pkg::branch_query_t q);
    meta_pkg::source_t exp_src;
    logic              exp_taken;
    @(posedge clk);
    query <= q;
    @(negedge clk); // query path is combinational.
    predict(q, exp_src, exp_taken);
    check_value($sformatf("source for query %02h", q), prediction_source, exp_src);
    check_value($sformatf("taken for query %02h", q), prediction_taken, exp_taken);
  endtask

  task automatic sweep_queries(input logic sp_expected);
    meta_pkg::branch_query_t q;
    for (int i = 0; i < 256; i++)
    begin
      q = i[7:0];
      query_check(q);
      if (q.kind >= 3'd6)
        check_value("invalid kind picks ghp", prediction_source, meta_pkg::SRC_GHP);
      else if (sp_expected)
      begin
        check_value("sp wins after reset", prediction_source, meta_pkg::SRC_SP);
        check_value("sp direction after reset", prediction_taken, q.sp_taken);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  task automatic test_after_reset();
    apply_reset();
    check_value("ack after reset", update_ack, 0);
    sweep_queries(1'b1);
  endtask

  task automatic test_handshake_timing();
    meta_pkg::branch_update_t rec;
    int                       rise;
    int                       fall;
    apply_reset();
    // sp wrong, lhp and ghp wrong, a second step would tie everything at 0.
    rec = make_rec(meta_pkg::BGEU, 1'b1, 2'b10, 2'b11, 1'b0);
    resolve(rec, 0, rise, fall);
    check_value("ack rise edges", rise, 2); // ack is registered at the edge that sees req.
    check_value("ack fall edges", fall, 2);
    query_check(rec.query);
    rec.query.kind = meta_pkg::BGE;
    resolve(rec, 5, rise, fall);
    check_value("ack rise edges with hold", rise, 2);
    check_value("ack fall edges with hold", fall, 2);
    query_check(rec.query);
  endtask

  task automatic test_source_switch();
    meta_pkg::branch_update_t rec;
    int                       switch_at;
    apply_reset();
    rec       = make_rec(meta_pkg::BEQ, 1'b1, 2'b10, 2'b01, 1'b0); // only ghp guesses right.
    switch_at = 0;
    for (int n = 1; n <= 4; n++)
    begin
      resolve_n(rec, 1);
      query_check(rec.query);
      if (switch_at == 0 && prediction_source == meta_pkg::SRC_GHP)
        switch_at = n;
    end
    check_value("update that switches to ghp", switch_at, 1); // sp 1 ties ghp 1.
  endtask

  task automatic test_saturation();
    meta_pkg::branch_update_t up;
    meta_pkg::branch_update_t wrong;
    apply_reset();
    up = make_rec(meta_pkg::BNE, 1'b1, 2'b00, 2'b11, 1'b1);
    resolve_n(up, 70);
    query_check(up.query); // sp and ghp both capped, tie.
    resolve_n(make_rec(meta_pkg::BNE, 1'b1, 2'b00, 2'b00, 1'b0), 1);
    query_check(up.query);
    for (int n = 0; n < 2; n++)
    begin
      resolve_n(make_rec(meta_pkg::BNE, 1'b0, 2'b00, 2'b11, 1'b0), 1);
      query_check(up.query);
    end
    wrong = make_rec(meta_pkg::BLT, 1'b1, 2'b10, 2'b10, 1'b0);
    resolve_n(wrong, 10);
    query_check(wrong.query);
    resolve_n(make_rec(meta_pkg::BLT, 1'b1, 2'b00, 2'b00, 1'b1), 1);
    query_check(wrong.query);
  endtask

  task automatic test_independence();
    apply_reset();
    resolve_n(make_rec(meta_pkg::BEQ, 1'b0, 2'b01, 2'b10, 1'b1), 5);
    sweep_queries(1'b0);
    resolve_n(make_rec(3'd6, 1'b1, 2'b11, 2'b11, 1'b1), 3);
    resolve_n(make_rec(3'd7, 1'b0, 2'b00, 2'b00, 1'b0), 3);
    sweep_queries(1'b0);
  endtask

  task automatic test_random();
    logic [31:0] bits;
    logic [31:0] hold;
    int          rise;
    int          fall;
    apply_reset();
    for (int n = 0; n < 200; n++)
    begin
      bits = take_bits(9);
      hold = take_bits(2);
      resolve(bits[8:0], int'(hold), rise, fall);
      bits = take_bits(8);
      query_check(bits[7:0]);
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  initial
  begin
    rst_n      <= 1'b0;
    query      <= '0;
    update     <= '0;
    update_req <= 1'b0;
    test_after_reset();
    test_handshake_timing();
    test_source_switch();
    test_saturation();
    test_independence();
    test_random();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
logic/meta_pkg.sv
logic/confidence_table.sv
logic/update_handshake.sv
logic/source_select.sv
logic/meta_predictor.sv
tests/meta_predictor_sva.sv
tests/tb_meta_predictor.sv

/* Makefile */
TOP = tb_meta_predictor

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@if grep -q "test failed" sim.log; then echo "simulation reported a failure"; exit 1; fi
	@grep -q "test passed" sim.log || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir sim.log
